//--- common/spi_cmd_pkg.sv
package spi_cmd_pkg;

    // ============================================================
    // Message and response framing
    // ============================================================
    localparam int unsigned MSG_LEN      = 64;  // Bits after the start bit
    localparam int unsigned RESP_LEN     = 64;
    localparam int unsigned MSG_TYPE_LEN = 8;   // Top bits of the message
    localparam int unsigned MSG_ARG_LEN  = MSG_LEN - MSG_TYPE_LEN;
    localparam int unsigned RESP_FLAG_BIT = 7;  // Set in the type when a response follows

    localparam int unsigned LED_WIDTH         = 4;
    localparam int unsigned ACCESS_MODE_WIDTH = 4;

    // Response field positions
    localparam int unsigned ECHO_ARG_LSB = 8;       // Argument in 63:8
    localparam int unsigned SD_MODE_MSB  = 63;      // Access mode in 63:60
    localparam int unsigned SD_VALID_BIT = 59;

    // ============================================================
    // Phase timing
    // ============================================================
    localparam int unsigned TURNAROUND_CYCLES = 8;
    localparam int unsigned CNT_WIDTH         = 7;
    localparam int unsigned RESP_CNT_WIDTH    = $clog2(RESP_LEN);

    // Counter reload values, one edge of each phase is spent in the FSM itself
    localparam logic [CNT_WIDTH-1:0] MSG_CNT_LOAD  = CNT_WIDTH'(MSG_LEN - 1);
    localparam logic [CNT_WIDTH-1:0] TURN_CNT_LOAD = CNT_WIDTH'(TURNAROUND_CYCLES - 2);

    // SD switch-function data block
    localparam int unsigned DAT_WORD_LEN     = 16;
    localparam int unsigned CMD6_BLOCK_WORDS = 32;
    localparam int unsigned CMD6_MODE_WORD   = 8;   // Ninth word
    localparam int unsigned CMD6_MODE_LSB    = 8;
    localparam int unsigned CMD6_IDX_WIDTH   = $clog2(CMD6_BLOCK_WORDS + 1);

    typedef enum logic [MSG_TYPE_LEN-1:0] {
        MSG_NOP       = 8'h00,
        MSG_LED_SET   = 8'h01,
        MSG_ECHO      = 8'h80,
        MSG_SD_STATUS = 8'h81
    } msg_type_e;

    typedef enum logic [2:0] {
        IDLE,
        MSG_IN,
        DECODE,
        TURNAROUND,
        RESP_OUT
    } cmd_state_e;

    typedef logic [MSG_ARG_LEN-1:0]       msg_arg_t;
    typedef logic [RESP_LEN-1:0]          resp_word_t;
    typedef logic [LED_WIDTH-1:0]         led_t;
    typedef logic [ACCESS_MODE_WIDTH-1:0] access_mode_t;

endpackage

//--- common/spi_resp_if.sv
`timescale 1ns/1ps

// Link from the command FSM to the response shifter
interface spi_resp_if;

    logic                    load;      // One-cycle strobe
    spi_cmd_pkg::resp_word_t word;
    logic                    busy;      // High while bits are on the pin
    logic                    bit_out;

    modport fsm (
        output load,
        output word,
        input  busy
    );

    modport tx (
        input  load,
        input  word,
        output busy,
        output bit_out
    );

endinterface

//--- hw/spi_bit_counter.sv
`timescale 1ns/1ps

module spi_bit_counter (
    input  logic                              sd_datInWrite_clk,
    input  logic                              spi_rst_,
    input  logic                              cnt_load,
    input  logic [spi_cmd_pkg::CNT_WIDTH-1:0] cnt_value,
    output logic                              cnt_zero
);

    logic [spi_cmd_pkg::CNT_WIDTH-1:0] cnt;

    // Down-counter, parks at zero until the next load
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            cnt <= '0;
        end else if (cnt_load) begin
            cnt <= cnt_value;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign cnt_zero = (cnt == '0);  // Seen by the FSM in the same cycle

endmodule

//--- hw/cmd6_capture.sv
`timescale 1ns/1ps

module cmd6_capture (
    input  logic                                 sd_datInWrite_clk,
    input  logic                                 spi_rst_,
    input  logic                                 dat_in_start,
    input  logic                                 dat_in_trigger,
    input  logic [spi_cmd_pkg::DAT_WORD_LEN-1:0] dat_in_data,
    output spi_cmd_pkg::access_mode_t            access_mode,
    output logic                                 mode_valid
);

    localparam logic [spi_cmd_pkg::CMD6_IDX_WIDTH-1:0] MODE_IDX =
        spi_cmd_pkg::CMD6_IDX_WIDTH'(spi_cmd_pkg::CMD6_MODE_WORD);
    localparam logic [spi_cmd_pkg::CMD6_IDX_WIDTH-1:0] LAST_IDX =
        spi_cmd_pkg::CMD6_IDX_WIDTH'(spi_cmd_pkg::CMD6_BLOCK_WORDS);

    logic [spi_cmd_pkg::CMD6_IDX_WIDTH-1:0] word_idx;   // Words seen in this block

    // ============================================================
    // Word index and access mode
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            word_idx    <= '0;
            access_mode <= '0;
            mode_valid  <= 1'b0;
        end else if (dat_in_start) begin
            // New block, old mode stays readable but is no longer valid
            word_idx   <= '0;
            mode_valid <= 1'b0;
        end else if (dat_in_trigger) begin
            if (word_idx == MODE_IDX) begin
                access_mode <= dat_in_data[spi_cmd_pkg::CMD6_MODE_LSB +:
                                           spi_cmd_pkg::ACCESS_MODE_WIDTH];
                mode_valid  <= 1'b1;
            end
            if (word_idx != LAST_IDX) begin
                word_idx <= word_idx + 1'b1;    // Saturates at end of block
            end
        end
    end

endmodule

//--- spi_cmd/msg_rx.sv
`timescale 1ns/1ps

module msg_rx (
    input  logic                   sd_datInWrite_clk,
    input  logic                   spi_rst_,
    input  logic                   spi_data_in,
    output spi_cmd_pkg::msg_type_e msg_type,
    output spi_cmd_pkg::msg_arg_t  msg_arg
);

    logic [spi_cmd_pkg::MSG_LEN-1:0]      msg_sr;
    logic [spi_cmd_pkg::MSG_TYPE_LEN-1:0] type_raw;

    // Free-running shift, MSB of the message ends up on top
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            msg_sr <= '0;
        end else begin
            msg_sr <= {msg_sr[spi_cmd_pkg::MSG_LEN-2:0], spi_data_in};
        end
    end

    assign type_raw = msg_sr[spi_cmd_pkg::MSG_LEN-1 -: spi_cmd_pkg::MSG_TYPE_LEN];
    assign msg_arg  = msg_sr[spi_cmd_pkg::MSG_ARG_LEN-1:0];

    // Unknown type codes decode as Nop
    always_comb begin
        case (type_raw)
            spi_cmd_pkg::MSG_LED_SET,
            spi_cmd_pkg::MSG_ECHO,
            spi_cmd_pkg::MSG_SD_STATUS: begin
                msg_type = spi_cmd_pkg::msg_type_e'(type_raw);
            end
            default: begin
                msg_type = spi_cmd_pkg::MSG_NOP;
            end
        endcase
    end

endmodule

//--- spi_cmd/resp_tx.sv
`timescale 1ns/1ps

module resp_tx (
    input  logic    sd_datInWrite_clk,
    input  logic    spi_rst_,
    spi_resp_if.tx  resp
);

    spi_cmd_pkg::resp_word_t                resp_sr;
    logic [spi_cmd_pkg::RESP_CNT_WIDTH-1:0] bits_left;  // Bits after the current one

    // ============================================================
    // Busy window, RESP_LEN cycles from the load
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            resp.busy <= 1'b0;
            bits_left <= '0;
        end else if (resp.load) begin
            resp.busy <= 1'b1;
            bits_left <= spi_cmd_pkg::RESP_CNT_WIDTH'(spi_cmd_pkg::RESP_LEN - 1);
        end else if (resp.busy) begin
            if (bits_left == '0) begin
                resp.busy <= 1'b0;  // Last bit just went out
            end else begin
                bits_left <= bits_left - 1'b1;
            end
        end
    end

    // Data path, MSB first
    always_ff @(posedge sd_datInWrite_clk) begin
        if (resp.load) begin
            resp_sr <= resp.word;
        end else if (resp.busy) begin
            resp_sr <= {resp_sr[spi_cmd_pkg::RESP_LEN-2:0], 1'b0};
        end
    end

    assign resp.bit_out = resp_sr[spi_cmd_pkg::RESP_LEN-1];

endmodule

//--- spi_cmd/cmd_fsm.sv
`timescale 1ns/1ps

module cmd_fsm (
    input  logic                              sd_datInWrite_clk,
    input  logic                              spi_rst_,
    input  logic                              spi_data_in,
    input  spi_cmd_pkg::msg_type_e            msg_type,
    input  spi_cmd_pkg::msg_arg_t             msg_arg,
    output logic                              cnt_load,
    output logic [spi_cmd_pkg::CNT_WIDTH-1:0] cnt_value,
    input  logic                              cnt_zero,
    input  spi_cmd_pkg::access_mode_t         access_mode,
    input  logic                              mode_valid,
    spi_resp_if.fsm                           resp,
    output spi_cmd_pkg::led_t                 led
);

    spi_cmd_pkg::cmd_state_e state;
    spi_cmd_pkg::cmd_state_e state_nxt;
    logic                    resp_pending;  // Decoded type wants a response
    spi_cmd_pkg::resp_word_t resp_word_q;

    // ============================================================
    // Next state and counter control
    // ============================================================
    always_comb begin
        state_nxt = state;
        cnt_load  = 1'b0;
        cnt_value = spi_cmd_pkg::MSG_CNT_LOAD;
        resp.load = 1'b0;

        case (state)
            spi_cmd_pkg::IDLE: begin
                if (spi_data_in) begin     // Start bit
                    state_nxt = spi_cmd_pkg::MSG_IN;
                    cnt_load  = 1'b1;
                end
            end
            spi_cmd_pkg::MSG_IN: begin
                if (cnt_zero) begin
                    state_nxt = spi_cmd_pkg::DECODE;    // Last message bit this edge
                end
            end
            spi_cmd_pkg::DECODE: begin
                state_nxt = spi_cmd_pkg::TURNAROUND;
                cnt_load  = 1'b1;
                cnt_value = spi_cmd_pkg::TURN_CNT_LOAD;
            end
            spi_cmd_pkg::TURNAROUND: begin
                if (cnt_zero) begin
                    if (resp_pending) begin
                        resp.load = 1'b1;   // First bit on the pin after this edge
                        state_nxt = spi_cmd_pkg::RESP_OUT;
                    end else begin
                        state_nxt = spi_cmd_pkg::IDLE;
                    end
                end
            end
            spi_cmd_pkg::RESP_OUT: begin
                // Once the shifter is done this state acts as IDLE, so a
                // start bit right after oe falls is not lost
                if (!resp.busy) begin
                    if (spi_data_in) begin
                        state_nxt = spi_cmd_pkg::MSG_IN;
                        cnt_load  = 1'b1;
                    end else begin
                        state_nxt = spi_cmd_pkg::IDLE;
                    end
                end
            end
            default: begin
                state_nxt = spi_cmd_pkg::IDLE;
            end
        endcase
    end

    // ============================================================
    // State, LED and response flag
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state        <= spi_cmd_pkg::IDLE;
            resp_pending <= 1'b0;
            led          <= '0;
        end else begin
            state <= state_nxt;
            if (state == spi_cmd_pkg::DECODE) begin
                resp_pending <= msg_type[spi_cmd_pkg::RESP_FLAG_BIT];
                if (msg_type == spi_cmd_pkg::MSG_LED_SET) begin
                    led <= msg_arg[spi_cmd_pkg::LED_WIDTH-1:0];
                end
            end
        end
    end

    // Response word built during DECODE
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == spi_cmd_pkg::DECODE) begin
            resp_word_q <= '0;
            case (msg_type)
                spi_cmd_pkg::MSG_ECHO: begin
                    resp_word_q[spi_cmd_pkg::RESP_LEN-1:spi_cmd_pkg::ECHO_ARG_LSB] <= msg_arg;
                end
                spi_cmd_pkg::MSG_SD_STATUS: begin
                    resp_word_q[spi_cmd_pkg::SD_MODE_MSB -: spi_cmd_pkg::ACCESS_MODE_WIDTH]
                        <= access_mode;
                    resp_word_q[spi_cmd_pkg::SD_VALID_BIT] <= mode_valid;
                end
                default: begin
                    resp_word_q <= '0;  // No response payload
                end
            endcase
        end
    end

    assign resp.word = resp_word_q;

endmodule

//--- hw/spi_cmd_top.sv
`timescale 1ns/1ps

module spi_cmd_top (
    input  logic                                 sd_datInWrite_clk,
    input  logic                                 spi_rst_,
    input  logic                                 spi_data_in,
    output logic                                 spi_data_out,
    output logic                                 spi_data_oe,
    output spi_cmd_pkg::led_t                    led,
    input  logic                                 dat_in_start,
    input  logic                                 dat_in_trigger,
    input  logic [spi_cmd_pkg::DAT_WORD_LEN-1:0] dat_in_data
);

    spi_cmd_pkg::msg_type_e            msg_type;
    spi_cmd_pkg::msg_arg_t             msg_arg;
    logic                              cnt_load;
    logic [spi_cmd_pkg::CNT_WIDTH-1:0] cnt_value;
    logic                              cnt_zero;
    spi_cmd_pkg::access_mode_t         access_mode;
    logic                              mode_valid;

    spi_resp_if resp_if ();

    // ============================================================
    // Command path
    // ============================================================
    msg_rx i_msg_rx (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .spi_data_in       (spi_data_in),
        .msg_type          (msg_type),
        .msg_arg           (msg_arg)
    );

    cmd_fsm i_cmd_fsm (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .spi_data_in       (spi_data_in),
        .msg_type          (msg_type),
        .msg_arg           (msg_arg),
        .cnt_load          (cnt_load),
        .cnt_value         (cnt_value),
        .cnt_zero          (cnt_zero),
        .access_mode       (access_mode),
        .mode_valid        (mode_valid),
        .resp              (resp_if.fsm),
        .led               (led)
    );

    spi_bit_counter i_spi_bit_counter (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .cnt_load          (cnt_load),
        .cnt_value         (cnt_value),
        .cnt_zero          (cnt_zero)
    );

    resp_tx i_resp_tx (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .resp              (resp_if.tx)
    );

    // SD data-in side
    cmd6_capture i_cmd6_capture (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .dat_in_start      (dat_in_start),
        .dat_in_trigger    (dat_in_trigger),
        .dat_in_data       (dat_in_data),
        .access_mode       (access_mode),
        .mode_valid        (mode_valid)
    );

    assign spi_data_oe  = resp_if.busy;     // Pin driven only during a response
    assign spi_data_out = resp_if.bit_out;

endmodule

//--- verif/spi_cmd_checker.sv
`timescale 1ns/1ps

module spi_cmd_checker (
    input logic              sd_datInWrite_clk,
    input logic              spi_rst_,
    input logic              spi_data_oe,
    input spi_cmd_pkg::led_t led
);

    localparam logic [7:0] RUN_MAX = 8'(spi_cmd_pkg::RESP_LEN);

    logic [7:0] oe_run;     // Consecutive cycles with oe high

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            oe_run <= '0;
        end else if (spi_data_oe) begin
            oe_run <= oe_run + 8'd1;
        end else begin
            oe_run <= '0;
        end
    end

    oe_low_in_reset: assert property (@(posedge sd_datInWrite_clk)
        !spi_rst_ |-> !spi_data_oe)
        else $error("spi_data_oe high while reset is applied");

    // Response window never longer than one word
    oe_not_too_long: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        spi_data_oe |-> (oe_run < RUN_MAX))
        else $error("spi_data_oe held longer than a response word");

    oe_full_length: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        $fell(spi_data_oe) |-> (oe_run == RUN_MAX))
        else $error("spi_data_oe fell before the whole response was sent");

    led_quiet_in_resp: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        !$stable(led) |-> !spi_data_oe)
        else $error("led changed while a response was on the pin");

endmodule

bind spi_cmd_top spi_cmd_checker i_spi_cmd_checker (
    .sd_datInWrite_clk (sd_datInWrite_clk),
    .spi_rst_          (spi_rst_),
    .spi_data_oe       (spi_data_oe),
    .led               (led)
);

//--- verif/tb_spi_cmd.sv
`timescale 1ns/1ps

module tb_spi_cmd;

    localparam int N_TESTS      = 9;
    localparam int MSG_BITS     = spi_cmd_pkg::MSG_LEN;
    localparam int RESP_BITS    = spi_cmd_pkg::RESP_LEN;
    localparam int BLOCK_WORDS  = spi_cmd_pkg::CMD6_BLOCK_WORDS;
    localparam int OE_TIMEOUT   = 4 * spi_cmd_pkg::TURNAROUND_CYCLES;
    localparam int QUIET_CYCLES = spi_cmd_pkg::TURNAROUND_CYCLES + 4;   // Past the turnaround

    logic                                 sd_datInWrite_clk;
    logic                                 spi_rst_;
    logic                                 spi_data_in;
    logic                                 spi_data_out;
    logic                                 spi_data_oe;
    spi_cmd_pkg::led_t                    led;
    logic                                 dat_in_start;
    logic                                 dat_in_trigger;
    logic [spi_cmd_pkg::DAT_WORD_LEN-1:0] dat_in_data;

    integer seed = 52756;
    int     err_count;
    int     fail_count;

    // ============================================================
    // Stimulus table, one row per test
    // ============================================================
    string                                tbl_name    [N_TESTS];
    logic                                 tbl_block   [N_TESTS];   // Data-in block first
    logic [spi_cmd_pkg::MSG_TYPE_LEN-1:0] tbl_type    [N_TESTS];
    spi_cmd_pkg::msg_arg_t                tbl_arg     [N_TESTS];
    logic                                 tbl_has_resp[N_TESTS];
    spi_cmd_pkg::resp_word_t              tbl_resp    [N_TESTS];
    spi_cmd_pkg::led_t                    tbl_led     [N_TESTS];
    logic [spi_cmd_pkg::DAT_WORD_LEN-1:0] blk_words   [BLOCK_WORDS];

    spi_cmd_top i_spi_cmd_top (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .spi_data_in       (spi_data_in),
        .spi_data_out      (spi_data_out),
        .spi_data_oe       (spi_data_oe),
        .led               (led),
        .dat_in_start      (dat_in_start),
        .dat_in_trigger    (dat_in_trigger),
        .dat_in_data       (dat_in_data)
    );

    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #20 sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    function automatic spi_cmd_pkg::msg_arg_t rand_arg();
        logic [63:0] rnd;
        rnd = {$random(seed), $random(seed)};
        return rnd[spi_cmd_pkg::MSG_ARG_LEN-1:0];
    endfunction

    task automatic set_entry(input int idx, input string name, input logic blk,
                             input logic [spi_cmd_pkg::MSG_TYPE_LEN-1:0] typ,
                             input spi_cmd_pkg::msg_arg_t arg, input logic has_resp,
                             input spi_cmd_pkg::resp_word_t resp, input spi_cmd_pkg::led_t led_exp);
        tbl_name[idx]     = name;
        tbl_block[idx]    = blk;
        tbl_type[idx]     = typ;
        tbl_arg[idx]      = arg;
        tbl_has_resp[idx] = has_resp;
        tbl_resp[idx]     = resp;
        tbl_led[idx]      = led_exp;
    endtask

    task automatic build_table();
        spi_cmd_pkg::msg_arg_t     arg;
        spi_cmd_pkg::led_t         led_cur;
        spi_cmd_pkg::access_mode_t mode;
        logic [31:0]               rnd;
        int                        w;
        led_cur = '0;
        for (w = 0; w < BLOCK_WORDS; w++) begin
            rnd          = $random(seed);
            blk_words[w] = rnd[15:0];
        end
        if (blk_words[8][11:8] == 4'h0) begin
            blk_words[8][11:8] = 4'h5;  // Nonzero so a missed capture shows
        end
        mode = blk_words[8][11:8];  // Access mode from the ninth word
        arg = rand_arg();
        set_entry(0, "echo_0", 1'b0, spi_cmd_pkg::MSG_ECHO, arg, 1'b1, {arg, 8'h00}, led_cur);
        arg = rand_arg();
        set_entry(1, "echo_1", 1'b0, spi_cmd_pkg::MSG_ECHO, arg, 1'b1, {arg, 8'h00}, led_cur);
        arg = rand_arg();
        arg[3:0] = ~led_cur;        // Differs from the reset value
        led_cur = arg[3:0];
        set_entry(2, "led_set_a", 1'b0, spi_cmd_pkg::MSG_LED_SET, arg, 1'b0, '0, led_cur);
        set_entry(3, "sd_status_empty", 1'b0, spi_cmd_pkg::MSG_SD_STATUS, rand_arg(), 1'b1,
                  '0, led_cur);
        arg = rand_arg();
        arg[3:0] = ~led_cur;        // Would show up on led if decoded as LED set
        set_entry(4, "nop", 1'b0, spi_cmd_pkg::MSG_NOP, arg, 1'b0, '0, led_cur);
        set_entry(5, "unknown_type", 1'b0, 8'h82, arg, 1'b0, '0, led_cur);
        set_entry(6, "sd_status_block", 1'b1, spi_cmd_pkg::MSG_SD_STATUS, rand_arg(), 1'b1,
                  {mode, 1'b1, 59'd0}, led_cur);
        arg = rand_arg();
        set_entry(7, "echo_b2b", 1'b0, spi_cmd_pkg::MSG_ECHO, arg, 1'b1, {arg, 8'h00}, led_cur);
        arg = rand_arg();
        arg[3:0] = ~led_cur;
        led_cur = arg[3:0];
        set_entry(8, "led_set_b2b", 1'b0, spi_cmd_pkg::MSG_LED_SET, arg, 1'b0, '0, led_cur);
    endtask

    // ============================================================
    // Bus drivers and response capture
    // ============================================================
    task automatic send_msg(input logic [spi_cmd_pkg::MSG_TYPE_LEN-1:0] typ,
                            input spi_cmd_pkg::msg_arg_t arg);
        logic [MSG_BITS-1:0] msg;
        int                  b;
        msg = {typ, arg};
        @(negedge sd_datInWrite_clk);
        spi_data_in = 1'b1;         // Start bit
        for (b = MSG_BITS - 1; b >= 0; b--) begin
            @(negedge sd_datInWrite_clk);
            spi_data_in = msg[b];
        end
        @(negedge sd_datInWrite_clk);
        spi_data_in = 1'b0;
    endtask

    task automatic send_block();
        int w;
        @(negedge sd_datInWrite_clk);
        dat_in_start = 1'b1;
        @(negedge sd_datInWrite_clk);
        dat_in_start = 1'b0;
        for (w = 0; w < BLOCK_WORDS; w++) begin
            dat_in_trigger = 1'b1;
            dat_in_data    = blk_words[w];
            @(negedge sd_datInWrite_clk);
        end
        dat_in_trigger = 1'b0;
    endtask

    task automatic get_resp(input string name, input logic expect_resp,
                            output spi_cmd_pkg::resp_word_t word);
        int cnt;
        int b;
        word = '0;
        cnt  = 0;
        if (expect_resp) begin
            while (!spi_data_oe && cnt < OE_TIMEOUT) begin
                @(negedge sd_datInWrite_clk);
                cnt++;
            end
            if (!spi_data_oe) begin
                $display("** Error: test %s, spi_data_oe never rose for the response", name);
                err_count++;
            end else begin
                for (b = RESP_BITS - 1; b >= 0; b--) begin
                    word[b] = spi_data_out;     // MSB first
                    if (b != 0) begin
                        @(negedge sd_datInWrite_clk);
                    end
                end
            end
        end else begin
            while (!spi_data_oe && cnt < QUIET_CYCLES) begin
                @(negedge sd_datInWrite_clk);
                cnt++;
            end
            if (spi_data_oe) begin
                $display("** Error: test %s, spi_data_oe rose but no response was expected",
                         name);
                err_count++;
            end
        end
    endtask

    task automatic compare_resp(input string name, input spi_cmd_pkg::resp_word_t exp,
                                input spi_cmd_pkg::resp_word_t act);
        if (act !== exp) begin
            $display("** Error: test %s response expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_led(input string name, input spi_cmd_pkg::led_t exp,
                               input spi_cmd_pkg::led_t act);
        if (act !== exp) begin
            $display("** Error: test %s led expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
            fail_count++;
        end
    endtask

    initial begin
        spi_cmd_pkg::resp_word_t resp;
        int                      errs_before;
        int                      i;
        spi_rst_       = 1'b0;
        spi_data_in    = 1'b0;
        dat_in_start   = 1'b0;
        dat_in_trigger = 1'b0;
        dat_in_data    = '0;
        err_count      = 0;
        fail_count     = 0;
        build_table();
        repeat (8) @(posedge sd_datInWrite_clk);
        @(negedge sd_datInWrite_clk);
        spi_rst_ = 1'b1;
        @(negedge sd_datInWrite_clk);

        errs_before = err_count;
        compare_led("reset", '0, led);
        if (spi_data_oe) begin
            $display("** Error: test reset, spi_data_oe is high after reset");
            err_count++;
        end
        report_test("reset", errs_before);

        for (i = 0; i < N_TESTS; i++) begin
            errs_before = err_count;
            if (tbl_block[i]) begin
                send_block();
            end
            send_msg(tbl_type[i], tbl_arg[i]);
            get_resp(tbl_name[i], tbl_has_resp[i], resp);
            if (tbl_has_resp[i]) begin
                compare_resp(tbl_name[i], tbl_resp[i], resp);
            end
            compare_led(tbl_name[i], tbl_led[i], led);
            report_test(tbl_name[i], errs_before);
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 N_TESTS + 1, N_TESTS + 1 - fail_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
common/spi_cmd_pkg.sv
common/spi_resp_if.sv
hw/spi_bit_counter.sv
hw/cmd6_capture.sv
spi_cmd/msg_rx.sv
spi_cmd/resp_tx.sv
spi_cmd/cmd_fsm.sv
hw/spi_cmd_top.sv
verif/spi_cmd_checker.sv
verif/tb_spi_cmd.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI command testbench with Verilator

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert --top-module tb_spi_cmd \
    -Mdir "$OBJ_DIR" -o sim_tb -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
